// ==== compile.f ====
rtl/addr_decode_pkg.sv
rtl/byte_window_select.sv
rtl/modrm_reg_select.sv
rtl/modrm_length_decode.sv
rtl/addressing_decode.sv
dv/addressing_decode_asserts.sv
dv/tb_addressing_decode.sv

// ==== run.sh ====
#!/bin/sh
# build and run the addressing decode testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
    --top-module tb_addressing_decode -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }

cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0

// ==== dv/tb_addressing_decode.sv ====
`timescale 1ns/1ns

module tb_addressing_decode;
    import addr_decode_pkg::*;

    localparam int N_RANDOM = 200;

    logic        clk;
    logic        rst;
    logic        decode_strobe;
    logic [WINDOW_BYTES-1:0][BYTE_W-1:0] packet;
    logic [PREFIX_SEL_W-1:0] num_prefixes_onehot;
    logic        is_double_op;
    logic        is_mod;
    logic        is_opsize_override;
    logic        result_valid;
    logic [LEN_W-1:0]   length_of_mod_sib_disp;
    logic [DISP_W-1:0]  disp_size;
    logic [REG_W-1:0]   r2_override_val;
    logic               use_r2;
    logic [REG_W-1:0]   r3_override_val;
    logic               use_r3;
    logic [SCALE_W-1:0] shift_r3_amount;
    logic               is_sib;

    // stim is {packet, prefix, double, is_mod, override}
    logic [54:0] tab_stim[$];
    // exp is {len, disp, r2, use_r2, r3, use_r3, shift, sib}
    logic [20:0] tab_exp[$];

    int errors;
    int cycles;
    int cycle_limit;

    addressing_decode u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: no end of test after %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [20:0] pack_exp(input logic [5:0] len, input logic [3:0] disp,
                                             input logic [2:0] r2, input logic u2,
                                             input logic [2:0] r3, input logic u3,
                                             input logic [1:0] sh, input logic sib);
        return {len, disp, r2, u2, r3, u3, sh, sib};
    endfunction

    // reference model built from the decode rules
    function automatic logic [20:0] model(input logic [47:0] pkt, input logic [3:0] pre,
                                          input logic dbl, input logic im,
                                          input logic ovr);
        int k;
        logic [7:0] m;
        logic [7:0] s;
        logic [1:0] md;
        logic [2:0] rm;
        logic sib;
        logic [2:0] r2;
        logic [2:0] r3;
        logic u2;
        logic u3;
        logic [5:0] len;
        logic [3:0] disp;
        k = 0;
        if (pre[0]) k = 0;
        else if (pre[1]) k = 1;
        else if (pre[2]) k = 2;
        else if (pre[3]) k = 3;
        k = k + int'(dbl);
        m = pkt[8*k +: 8];
        s = pkt[8*(k+1) +: 8];
        md = m[7:6];
        rm = m[2:0];
        sib = im && !ovr && md != 2'b11 && rm == 3'd4;
        if (sib) begin
            r2 = s[2:0];
            r3 = s[5:3];
        end else if (ovr && md != 2'b11) begin
            r2 = (rm == 3'd2 || rm == 3'd3 || rm == 3'd6) ? 3'd5 : 3'd3;
            r3 = rm[0] ? 3'd7 : 3'd6;
        end else begin
            r2 = rm;
            r3 = s[5:3];
        end
        u2 = 1'b0;
        u3 = 1'b0;
        len = 6'b000001;
        disp = 4'b0001;
        if (im) begin
            if (md == 2'b11) u2 = 1'b1;
            else if (!ovr) u2 = !(md == 2'b00 && rm == 3'd5);
            else u2 = rm < 3'd4 || (rm == 3'd7 && md == 2'b00) || (rm >= 3'd6 && md != 2'b00);
            u3 = ovr ? (md != 2'b11 && rm < 3'd6) : sib;
            case (md)
                2'b11: begin
                    len = 6'b000010;
                end
                2'b00: begin
                    if (!ovr && rm == 3'd5) begin
                        len = 6'b010000;
                        disp = 4'b1000;
                    end else if (ovr && rm == 3'd6) begin
                        len = 6'b001000;
                        disp = 4'b0100;
                    end else begin
                        len = sib ? 6'b000100 : 6'b000010;
                    end
                end
                2'b01: begin
                    len = sib ? 6'b001000 : 6'b000100;
                    disp = 4'b0010;
                end
                default: begin
                    len = ovr ? 6'b001000 : (sib ? 6'b100000 : 6'b010000);
                    disp = ovr ? 4'b0100 : 4'b1000;
                end
            endcase
        end
        return {len, disp, r2, u2, r3, u3, (sib ? s[7:6] : 2'b00), sib};
    endfunction

    task automatic add_case(input logic [47:0] pkt, input logic [3:0] pre, input logic dbl,
                            input logic im, input logic ovr, input logic [20:0] exp);
        tab_stim.push_back({pkt, pre, dbl, im, ovr});
        tab_exp.push_back(exp);
    endtask

    task automatic add_pair(input logic [7:0] m, input logic [7:0] s, input logic im,
                            input logic ovr, input logic [20:0] exp);
        add_case({32'hA5A5_A5A5, s, m}, 4'b0000, 1'b0, im, ovr, exp);
    endtask

    task automatic build_table();
        logic [47:0] win;
        logic [3:0] pres[8] = '{4'h0, 4'h1, 4'h2, 4'h4, 4'h8, 4'h6, 4'hF, 4'hC};
        int cnt[8] = '{0, 0, 1, 2, 3, 1, 0, 2};
        logic [2:0] r2_16[8] = '{3, 3, 5, 5, 3, 3, 5, 3};
        logic u2_ind[8] = '{1, 1, 1, 1, 0, 0, 0, 1};
        logic u2_d8[8] = '{1, 1, 1, 1, 0, 0, 1, 1};
        int k;
        // each byte carries its own position in rm and in the index field
        for (int j = 0; j < WINDOW_BYTES; j++) begin
            win[8*j +: 8] = 8'hC0 | 8'(j << 3) | 8'(j);
        end
        for (int i = 0; i < 8; i++) begin
            for (int d = 0; d < 2; d++) begin
                k = cnt[i] + d;
                add_case(win, pres[i], d[0], 1'b1, 1'b0,
                         pack_exp(LEN_1, DISP_0, 3'(k), 1'b1, 3'(k + 1), 1'b0, 2'd0, 1'b0));
            end
        end
        // 32-bit forms
        add_pair(8'h04, 8'h8D, 1, 0, pack_exp(LEN_2, DISP_0, 5, 1, 1, 1, 2, 1));
        add_pair(8'h05, 8'h8D, 1, 0, pack_exp(LEN_5, DISP_4, 5, 0, 1, 0, 0, 0));
        add_pair(8'h44, 8'h8D, 1, 0, pack_exp(LEN_3, DISP_1, 5, 1, 1, 1, 2, 1));
        add_pair(8'h84, 8'h8D, 1, 0, pack_exp(LEN_6, DISP_4, 5, 1, 1, 1, 2, 1));
        add_pair(8'h41, 8'h8D, 1, 0, pack_exp(LEN_2, DISP_1, 1, 1, 1, 0, 0, 0));
        add_pair(8'h81, 8'h8D, 1, 0, pack_exp(LEN_5, DISP_4, 1, 1, 1, 0, 0, 0));
        add_pair(8'h03, 8'h8D, 1, 0, pack_exp(LEN_1, DISP_0, 3, 1, 1, 0, 0, 0));
        add_pair(8'hC4, 8'h8D, 1, 0, pack_exp(LEN_1, DISP_0, 4, 1, 1, 0, 0, 0));
        add_pair(8'h04, 8'h8D, 0, 0, pack_exp(LEN_0, DISP_0, 4, 0, 1, 0, 0, 0));
        add_pair(8'hE4, 8'h3A, 1, 0, pack_exp(LEN_1, DISP_0, 4, 1, 7, 0, 0, 0));
        // 16-bit forms, no sib even for rm 4
        for (int rm = 0; rm < 8; rm++) begin
            add_pair(8'(rm), 8'h8D, 1, 1,
                     pack_exp(rm == 6 ? LEN_3 : LEN_1, rm == 6 ? DISP_2 : DISP_0, r2_16[rm],
                              u2_ind[rm], rm % 2 ? 3'd7 : 3'd6, rm < 6, 0, 0));
            add_pair(8'h40 | 8'(rm), 8'h8D, 1, 1,
                     pack_exp(LEN_2, DISP_1, r2_16[rm], u2_d8[rm],
                              rm % 2 ? 3'd7 : 3'd6, rm < 6, 0, 0));
        end
        add_pair(8'h86, 8'h8D, 1, 1, pack_exp(LEN_3, DISP_2, 5, 1, 6, 0, 0, 0));
        add_pair(8'hC2, 8'h8D, 1, 1, pack_exp(LEN_1, DISP_0, 2, 1, 1, 0, 0, 0));
        add_pair(8'h04, 8'h8D, 0, 1, pack_exp(LEN_0, DISP_0, 3, 0, 6, 0, 0, 0));
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic compare_outputs(input logic [20:0] exp, input string tag);
        check(32'(length_of_mod_sib_disp), 32'(exp[20:15]), {tag, " length"});
        check(32'(disp_size), 32'(exp[14:11]), {tag, " disp_size"});
        check(32'(r2_override_val), 32'(exp[10:8]), {tag, " r2"});
        check(32'(use_r2), 32'(exp[7]), {tag, " use_r2"});
        check(32'(r3_override_val), 32'(exp[6:4]), {tag, " r3"});
        check(32'(use_r3), 32'(exp[3]), {tag, " use_r3"});
        check(32'(shift_r3_amount), 32'(exp[2:1]), {tag, " shift"});
        check(32'(is_sib), 32'(exp[0]), {tag, " is_sib"});
    endtask

    task automatic drive(input logic [54:0] stim);
        decode_strobe       <= 1'b1;
        packet              <= stim[54:7];
        num_prefixes_onehot <= stim[6:3];
        is_double_op        <= stim[2];
        is_mod              <= stim[1];
        is_opsize_override  <= stim[0];
    endtask

    initial begin
        logic [54:0] stim;
        logic [20:0] prev_exp;
        string tag;
        errors = 0;
        cycles = 0;
        cycle_limit = 1000;
        rst = 1'b1;
        decode_strobe = 1'b0;
        packet = '0;
        num_prefixes_onehot = '0;
        is_double_op = 1'b0;
        is_mod = 1'b0;
        is_opsize_override = 1'b0;
        void'($urandom(32'h872b2e1e));
        build_table();
        cycle_limit = (tab_stim.size() + N_RANDOM) * 4 + 50;

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // one strobe per case, then a quiet cycle to see the outputs hold
        for (int i = 0; i < tab_stim.size(); i++) begin
            tag = $sformatf("case %0d", i);
            @(posedge clk);
            drive(tab_stim[i]);
            @(posedge clk);
            decode_strobe <= 1'b0;
            // new inputs without a strobe must not reach the outputs
            packet             <= ~packet;
            is_mod             <= ~is_mod;
            is_opsize_override <= ~is_opsize_override;
            @(negedge clk);
            check(32'(result_valid), 32'd1, {tag, " result_valid"});
            compare_outputs(tab_exp[i], tag);
            @(negedge clk);
            check(32'(result_valid), 32'd0, {tag, " result_valid after"});
            compare_outputs(tab_exp[i], {tag, " held"});
        end

        // random cases with back-to-back strobes
        prev_exp = '0;
        for (int i = 0; i <= N_RANDOM; i++) begin
            @(posedge clk);
            if (i < N_RANDOM) begin
                stim = {$urandom, $urandom};
                drive(stim);
            end else begin
                decode_strobe <= 1'b0;
            end
            if (i > 0) begin
                @(negedge clk);
                tag = $sformatf("random %0d", i - 1);
                check(32'(result_valid), 32'd1, {tag, " result_valid"});
                compare_outputs(prev_exp, tag);
            end
            prev_exp = model(stim[54:7], stim[6:3], stim[2], stim[1], stim[0]);
        end

        @(negedge clk);
        check(32'(result_valid), 32'd0, "result_valid after last strobe");
        $display("%0d errors over %0d table and %0d random cases", errors,
                 tab_stim.size(), N_RANDOM);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/addressing_decode_asserts.sv ====
`timescale 1ns/1ns

module addressing_decode_asserts (
    input logic                                 clk,
    input logic                                 rst,
    input logic                                 decode_strobe,
    input logic                                 result_valid,
    input logic [addr_decode_pkg::LEN_W-1:0]    length_of_mod_sib_disp,
    input logic [addr_decode_pkg::DISP_W-1:0]   disp_size,
    input logic [addr_decode_pkg::REG_W-1:0]    r2_override_val,
    input logic [addr_decode_pkg::REG_W-1:0]    r3_override_val,
    input logic [addr_decode_pkg::SCALE_W-1:0]  shift_r3_amount,
    input logic                                 use_r2,
    input logic                                 use_r3,
    input logic                                 is_sib
);
    import addr_decode_pkg::*;

    // valid exactly one cycle after a strobe, never otherwise
    assert property (@(posedge clk) disable iff (rst) decode_strobe |=> result_valid)
        else $error("result_valid missing one cycle after strobe");
    assert property (@(posedge clk) disable iff (rst) !decode_strobe |=> !result_valid)
        else $error("result_valid without a strobe");

    assert property (@(posedge clk) disable iff (rst)
        result_valid |-> ($onehot(length_of_mod_sib_disp) && $onehot(disp_size)))
        else $error("length or displacement code not one-hot");

    assert property (@(posedge clk) rst |=> (!result_valid && length_of_mod_sib_disp == '0
        && disp_size == '0 && r2_override_val == '0 && r3_override_val == '0
        && shift_r3_amount == '0 && !use_r2 && !use_r3 && !is_sib))
        else $error("outputs not cleared by reset");

endmodule

bind addressing_decode addressing_decode_asserts u_asserts (.*);

// ==== rtl/addressing_decode.sv ====
`timescale 1ns/1ns

module addressing_decode (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 decode_strobe,
    // packet[0] is the first instruction byte
    input  logic [addr_decode_pkg::WINDOW_BYTES-1:0][addr_decode_pkg::BYTE_W-1:0] packet,
    input  logic [addr_decode_pkg::PREFIX_SEL_W-1:0] num_prefixes_onehot,
    input  logic                                 is_double_op,
    input  logic                                 is_mod,
    input  logic                                 is_opsize_override,
    output logic                                 result_valid,
    output logic [addr_decode_pkg::LEN_W-1:0]    length_of_mod_sib_disp,
    output logic [addr_decode_pkg::DISP_W-1:0]   disp_size,
    output logic [addr_decode_pkg::REG_W-1:0]    r2_override_val,
    output logic                                 use_r2,
    output logic [addr_decode_pkg::REG_W-1:0]    r3_override_val,
    output logic                                 use_r3,
    output logic [addr_decode_pkg::SCALE_W-1:0]  shift_r3_amount,
    output logic                                 is_sib
);
    import addr_decode_pkg::*;

    logic [BYTE_W-1:0]  modrm_byte;
    logic [BYTE_W-1:0]  sib_byte;

    logic               is_sib_next;
    logic [REG_W-1:0]   r2_next;
    logic               use_r2_next;
    logic [REG_W-1:0]   r3_next;
    logic               use_r3_next;
    logic [SCALE_W-1:0] shift_next;
    logic [LEN_W-1:0]   length_next;
    logic [DISP_W-1:0]  disp_next;

    byte_window_select u_window (
        .packet              (packet),
        .num_prefixes_onehot (num_prefixes_onehot),
        .is_double_op        (is_double_op),
        .modrm_byte          (modrm_byte),
        .sib_byte            (sib_byte)
    );

    modrm_reg_select u_reg_sel (
        .modrm_byte         (modrm_byte),
        .sib_byte           (sib_byte),
        .is_mod             (is_mod),
        .is_opsize_override (is_opsize_override),
        .is_sib             (is_sib_next),
        .r2_override_val    (r2_next),
        .use_r2             (use_r2_next),
        .r3_override_val    (r3_next),
        .use_r3             (use_r3_next),
        .shift_r3_amount    (shift_next)
    );

    modrm_length_decode u_len (
        .modrm_byte             (modrm_byte),
        .is_sib                 (is_sib_next),
        .is_mod                 (is_mod),
        .is_opsize_override     (is_opsize_override),
        .length_of_mod_sib_disp (length_next),
        .disp_size              (disp_next)
    );

    // results held until the next strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid           <= 1'b0;
            length_of_mod_sib_disp <= '0;
            disp_size              <= '0;
            r2_override_val        <= '0;
            use_r2                 <= 1'b0;
            r3_override_val        <= '0;
            use_r3                 <= 1'b0;
            shift_r3_amount        <= '0;
            is_sib                 <= 1'b0;
        end else begin
            result_valid <= decode_strobe;
            if (decode_strobe) begin
                length_of_mod_sib_disp <= length_next;
                disp_size              <= disp_next;
                r2_override_val        <= r2_next;
                use_r2                 <= use_r2_next;
                r3_override_val        <= r3_next;
                use_r3                 <= use_r3_next;
                shift_r3_amount        <= shift_next;
                is_sib                 <= is_sib_next;
            end
        end
    end

endmodule

// ==== rtl/modrm_length_decode.sv ====
`timescale 1ns/1ns

module modrm_length_decode (
    input  logic [addr_decode_pkg::BYTE_W-1:0] modrm_byte,
    input  logic                               is_sib,
    input  logic                               is_mod,
    input  logic                               is_opsize_override,
    output logic [addr_decode_pkg::LEN_W-1:0]  length_of_mod_sib_disp,
    output logic [addr_decode_pkg::DISP_W-1:0] disp_size
);
    import addr_decode_pkg::*;

    mod_mode_e        mod_f;
    logic [REG_W-1:0] rm;

    assign mod_f = mod_mode_e'(modrm_byte[7:6]);
    assign rm    = modrm_byte[2:0];

    always_comb begin
        length_of_mod_sib_disp = LEN_0;
        disp_size              = DISP_0;

        if (is_mod && !is_opsize_override) begin
            // 32-bit addressing
            case (mod_f)
                MOD_REG: begin
                    length_of_mod_sib_disp = LEN_1;
                    disp_size              = DISP_0;
                end
                MOD_INDIRECT: begin
                    if (rm == RM_DISP32) begin
                        length_of_mod_sib_disp = LEN_5;
                        disp_size              = DISP_4;
                    end else if (is_sib) begin
                        length_of_mod_sib_disp = LEN_2;
                        disp_size              = DISP_0;
                    end else begin
                        length_of_mod_sib_disp = LEN_1;
                        disp_size              = DISP_0;
                    end
                end
                MOD_DISP8: begin
                    length_of_mod_sib_disp = is_sib ? LEN_3 : LEN_2;
                    disp_size              = DISP_1;
                end
                MOD_DISP_FULL: begin
                    length_of_mod_sib_disp = is_sib ? LEN_6 : LEN_5;
                    disp_size              = DISP_4;
                end
                default: begin
                    length_of_mod_sib_disp = LEN_0;
                    disp_size              = DISP_0;
                end
            endcase
        end else if (is_mod) begin
            // 16-bit addressing, no sib and at most two displacement bytes
            case (mod_f)
                MOD_REG: begin
                    length_of_mod_sib_disp = LEN_1;
                    disp_size              = DISP_0;
                end
                MOD_INDIRECT: begin
                    if (rm == RM_DISP16) begin
                        length_of_mod_sib_disp = LEN_3;
                        disp_size              = DISP_2;
                    end else begin
                        length_of_mod_sib_disp = LEN_1;
                        disp_size              = DISP_0;
                    end
                end
                MOD_DISP8: begin
                    length_of_mod_sib_disp = LEN_2;
                    disp_size              = DISP_1;
                end
                MOD_DISP_FULL: begin
                    length_of_mod_sib_disp = LEN_3;
                    disp_size              = DISP_2;
                end
                default: begin
                    length_of_mod_sib_disp = LEN_0;
                    disp_size              = DISP_0;
                end
            endcase
        end
    end

endmodule

// ==== rtl/modrm_reg_select.sv ====
`timescale 1ns/1ns

module modrm_reg_select (
    input  logic [addr_decode_pkg::BYTE_W-1:0]  modrm_byte,
    input  logic [addr_decode_pkg::BYTE_W-1:0]  sib_byte,
    input  logic                                is_mod,
    input  logic                                is_opsize_override,
    output logic                                is_sib,
    output logic [addr_decode_pkg::REG_W-1:0]   r2_override_val,
    output logic                                use_r2,
    output logic [addr_decode_pkg::REG_W-1:0]   r3_override_val,
    output logic                                use_r3,
    output logic [addr_decode_pkg::SCALE_W-1:0] shift_r3_amount
);
    import addr_decode_pkg::*;

    mod_mode_e          mod_f;
    logic [REG_W-1:0]   rm;
    logic [SCALE_W-1:0] sib_scale;
    logic [REG_W-1:0]   sib_index;
    logic [REG_W-1:0]   sib_base;
    logic               mode32;
    logic               mem_operand;

    assign mod_f     = mod_mode_e'(modrm_byte[7:6]);
    assign rm        = modrm_byte[2:0];
    assign sib_scale = sib_byte[7:6];
    assign sib_index = sib_byte[5:3];
    assign sib_base  = sib_byte[2:0];

    assign mode32      = !is_opsize_override;
    assign mem_operand = (mod_f != MOD_REG);

    // only 32-bit memory forms carry a sib byte
    assign is_sib = is_mod && mode32 && mem_operand && (rm == RM_SIB);

    always_comb begin
        if (is_sib) begin
            r2_override_val = sib_base;
            r3_override_val = sib_index;
        end else if (!mode32 && mem_operand) begin
            // bx/bp base, si/di index of the 16-bit forms
            if (rm == 3'd2 || rm == 3'd3 || rm == RM_DISP16) begin
                r2_override_val = REG_BP;
            end else begin
                r2_override_val = REG_BX;
            end
            r3_override_val = rm[0] ? REG_DI : REG_SI;
        end else begin
            r2_override_val = rm;
            r3_override_val = sib_index;
        end
    end

    assign shift_r3_amount = is_sib ? sib_scale : '0;

    always_comb begin
        use_r2 = 1'b0;
        use_r3 = 1'b0;
        if (is_mod) begin
            if (mod_f == MOD_REG) begin
                use_r2 = 1'b1;
            end else if (mode32) begin
                // absolute disp32 has no base
                use_r2 = !(mod_f == MOD_INDIRECT && rm == RM_DISP32);
            end else begin
                use_r2 = (rm <= 3'd3)
                      || (rm == 3'd7 && mod_f == MOD_INDIRECT)
                      || (rm >= RM_DISP16 && mod_f != MOD_INDIRECT);
            end

            if (mode32) begin
                use_r3 = is_sib;
            end else begin
                use_r3 = mem_operand && (rm <= 3'd5);
            end
        end
    end

endmodule

// ==== rtl/byte_window_select.sv ====
`timescale 1ns/1ns

module byte_window_select (
    // packet[0] is the first instruction byte
    input  logic [addr_decode_pkg::WINDOW_BYTES-1:0][addr_decode_pkg::BYTE_W-1:0] packet,
    input  logic [addr_decode_pkg::PREFIX_SEL_W-1:0] num_prefixes_onehot,
    input  logic                                     is_double_op,
    output logic [addr_decode_pkg::BYTE_W-1:0]       modrm_byte,
    output logic [addr_decode_pkg::BYTE_W-1:0]       sib_byte
);
    import addr_decode_pkg::*;

    logic [2:0] prefix_count;
    // offset of the modrm byte inside the window
    logic [2:0] modrm_pos;

    always_comb begin
        prefix_count = 3'd0;
        // scan downwards so the lowest set bit is the one that sticks
        for (int i = PREFIX_SEL_W - 1; i >= 0; i--) begin
            if (num_prefixes_onehot[i]) begin
                prefix_count = 3'(i);
            end
        end
    end

    // two-byte opcodes push modrm one byte further out
    assign modrm_pos = prefix_count + {2'b00, is_double_op};

    always_comb begin
        modrm_byte = '0;
        sib_byte   = '0;
        for (int j = 0; j < WINDOW_BYTES - 1; j++) begin
            if (modrm_pos == 3'(j)) begin
                modrm_byte = packet[j];
                sib_byte   = packet[j+1];
            end
        end
    end

endmodule

// ==== rtl/addr_decode_pkg.sv ====
package addr_decode_pkg;

    // field and bus widths
    localparam int BYTE_W       = 8;
    localparam int WINDOW_BYTES = 6;
    localparam int PREFIX_SEL_W = 4;
    localparam int REG_W        = 3;
    localparam int SCALE_W      = 2;
    localparam int LEN_W        = 6;
    localparam int DISP_W       = 4;

    // one-hot length of modrm + sib + displacement
    localparam logic [LEN_W-1:0] LEN_0 = 6'b000001;
    localparam logic [LEN_W-1:0] LEN_1 = 6'b000010;
    localparam logic [LEN_W-1:0] LEN_2 = 6'b000100;
    localparam logic [LEN_W-1:0] LEN_3 = 6'b001000;
    localparam logic [LEN_W-1:0] LEN_5 = 6'b010000;
    localparam logic [LEN_W-1:0] LEN_6 = 6'b100000;

    // one-hot displacement size in bytes
    localparam logic [DISP_W-1:0] DISP_0 = 4'b0001;
    localparam logic [DISP_W-1:0] DISP_1 = 4'b0010;
    localparam logic [DISP_W-1:0] DISP_2 = 4'b0100;
    localparam logic [DISP_W-1:0] DISP_4 = 4'b1000;

    // special rm encodings
    localparam logic [REG_W-1:0] RM_SIB    = 3'd4;
    localparam logic [REG_W-1:0] RM_DISP32 = 3'd5;
    localparam logic [REG_W-1:0] RM_DISP16 = 3'd6;

    // 16-bit addressing registers
    localparam logic [REG_W-1:0] REG_BX = 3'd3;
    localparam logic [REG_W-1:0] REG_BP = 3'd5;
    localparam logic [REG_W-1:0] REG_SI = 3'd6;
    localparam logic [REG_W-1:0] REG_DI = 3'd7;

    // mod field of the modrm byte
    typedef enum logic [1:0] {
        MOD_INDIRECT  = 2'b00,
        MOD_DISP8     = 2'b01,
        MOD_DISP_FULL = 2'b10,
        MOD_REG       = 2'b11
    } mod_mode_e;

endpackage
